// File: design/vdp_host_regs.sv
// Host register decoder, writes use valid/ready and stall only on a full VRAM queue
// The VRAM address advances when a data write is queued, not when it reaches VRAM
// Reads have no handshake and return raster position on the next cycle

`timescale 1ns/1ps

module vdp_host_regs import vdp_pkg::*; (
    input logic clk,
    input logic reset,
    input host_addr_t host_address,
    input word_t host_write_data,
    input logic host_write_en,
    input logic host_read_en,
    input raster_x_t raster_x,
    input raster_y_t raster_y,
    input logic push_ready,
    output word_t host_read_data,
    output logic host_ready,
    output logic push_valid,
    output vram_write_t push_item,
    output logic pal_we,
    output pal_index_t pal_addr,
    output word_t pal_data,
    output pal_index_t backdrop
);
    regs_state_t state;
    word_t read_value;
    vram_addr_t vram_addr;
    vram_addr_t vram_inc;
    logic write_fire;

    // One ready for every register keeps the host side simple
    assign host_ready = push_ready;
    assign write_fire = host_write_en && host_ready;

    assign push_valid = host_write_en && (host_address == REG_VRAM_DATA);
    assign push_item = '{addr: vram_addr, data: host_write_data};

    // Palette data goes straight to the RAM in the accepting cycle
    assign pal_we = write_fire && (host_address == REG_PALETTE_DATA);
    assign pal_data = host_write_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            pal_addr <= '0;
            backdrop <= '0;
            vram_addr <= '0;
            vram_inc <= '0;
        end else if (write_fire) begin
            case (host_address)
                REG_PALETTE_ADDR: pal_addr <= host_write_data[7:0];
                REG_PALETTE_DATA: pal_addr <= pal_addr + 1'b1;
                REG_VRAM_ADDR: vram_addr <= host_write_data[14:0];
                // Wraps at 15 bits
                REG_VRAM_DATA: vram_addr <= vram_addr + vram_inc;
                REG_VRAM_INC: vram_inc <= host_write_data[14:0];
                REG_BACKDROP: backdrop <= host_write_data[7:0];
                default: ;
            endcase
        end
    end

    // Read FSM, output stays zero until the first read
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else if (host_read_en) begin
            state <= READ_HOLD;
        end
    end

    always_ff @(posedge clk) begin
        if (host_read_en) begin
            read_value <= (host_address == REG_RASTER_Y) ? word_t'(raster_y) : word_t'(raster_x);
        end
    end

    assign host_read_data = (state == READ_HOLD) ? read_value : '0;

endmodule

// File: design/vdp_palette_output.sv
// Palette RAM and the backdrop output stage, two cycles from active_display to RGB
// Only the low 12 bits of a palette entry reach the output
// Palette contents start as black

`timescale 1ns/1ps

module vdp_palette_output import vdp_pkg::*; (
    input logic clk,
    input logic pal_we,
    input pal_index_t pal_addr,
    input word_t pal_data,
    input pal_index_t backdrop,
    input logic active_display,
    output logic [3:0] r,
    output logic [3:0] g,
    output logic [3:0] b
);
    word_t palette_ram [256];
    word_t backdrop_entry;
    logic active_d;
    color_t color;

    initial begin
        for (int i = 0; i < 256; i++) begin
            palette_ram[i] = '0;
        end
    end

    // Stage 1, RAM write port and registered backdrop read
    always_ff @(posedge clk) begin
        if (pal_we) begin
            palette_ram[pal_addr] <= pal_data;
        end
        backdrop_entry <= palette_ram[backdrop];
        active_d <= active_display;
    end

    assign color = backdrop_entry[11:0];

    // Stage 2, blank outside the active area
    always_ff @(posedge clk) begin
        {r, g, b} <= active_d ? color : '0;
    end

endmodule

// File: design/vdp_pkg.sv
// Shared types and the host register map for the display processor core
// Only the palette, backdrop and VRAM write registers are decoded
// Reads return raster position only

package vdp_pkg;

    typedef logic [4:0] host_addr_t;
    typedef logic [15:0] word_t;
    // Bit 0 picks the even or odd port, upper bits address within the port
    typedef logic [14:0] vram_addr_t;
    typedef logic [13:0] port_addr_t;
    typedef logic [7:0] pal_index_t;
    // Red in the top nibble
    typedef logic [11:0] color_t;
    typedef logic [11:0] raster_x_t;
    typedef logic [10:0] raster_y_t;

    typedef struct packed {
        vram_addr_t addr;
        word_t data;
    } vram_write_t;

    typedef enum logic {IDLE, READ_HOLD} regs_state_t;

    // Write registers
    localparam host_addr_t REG_PALETTE_ADDR = 5'd2;
    localparam host_addr_t REG_PALETTE_DATA = 5'd3;
    localparam host_addr_t REG_VRAM_ADDR = 5'd4;
    localparam host_addr_t REG_VRAM_DATA = 5'd5;
    localparam host_addr_t REG_VRAM_INC = 5'd6;
    localparam host_addr_t REG_BACKDROP = 5'd14;

    // Read registers
    localparam host_addr_t REG_RASTER_X = 5'd0;
    localparam host_addr_t REG_RASTER_Y = 5'd2;

    // raster_x[2:0] phase that owns the VRAM write ports
    localparam logic [2:0] VRAM_WRITE_SLOT = 3'd7;

endpackage

// File: design/vdp_top.sv
// Display processor core with raster timing, host registers, palette and VRAM writes
// Every pixel shows the backdrop palette entry, there are no layers or sprites
// Timing parameters default to 640x480, VRAM ports are write only

`timescale 1ns/1ps

module vdp_top import vdp_pkg::*; #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT = 16,
    parameter int H_SYNC = 96,
    parameter int H_BACK = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT = 11,
    parameter int V_SYNC = 2,
    parameter int V_BACK = 31,
    parameter int FIFO_DEPTH = 4
) (
    input logic clk,
    input logic reset,
    input host_addr_t host_address,
    input word_t host_write_data,
    input logic host_write_en,
    input logic host_read_en,
    output word_t host_read_data,
    output logic host_ready,
    output logic [3:0] r,
    output logic [3:0] g,
    output logic [3:0] b,
    output logic vga_hsync,
    output logic vga_vsync,
    output logic active_display,
    output logic line_ended,
    output logic frame_ended,
    output logic active_frame_ended,
    output port_addr_t vram_address_even,
    output port_addr_t vram_address_odd,
    output word_t vram_write_data_even,
    output word_t vram_write_data_odd,
    output logic vram_we_even,
    output logic vram_we_odd
);
    raster_x_t raster_x;
    raster_y_t raster_y;

    logic push_valid;
    logic push_ready;
    vram_write_t push_item;
    logic pop_valid;
    logic pop_ready;
    vram_write_t pop_item;

    logic pal_we;
    pal_index_t pal_addr;
    word_t pal_data;
    pal_index_t backdrop;

    vdp_video_timing #(
        .H_ACTIVE(H_ACTIVE),
        .H_FRONT(H_FRONT),
        .H_SYNC(H_SYNC),
        .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE),
        .V_FRONT(V_FRONT),
        .V_SYNC(V_SYNC),
        .V_BACK(V_BACK)
    ) video_timing (
        .clk(clk),
        .reset(reset),
        .raster_x(raster_x),
        .raster_y(raster_y),
        .hsync(vga_hsync),
        .vsync(vga_vsync),
        .active_display(active_display),
        .line_ended(line_ended),
        .frame_ended(frame_ended),
        .active_frame_ended(active_frame_ended)
    );

    // Producer, decodes host writes
    vdp_host_regs host_regs (
        .clk(clk),
        .reset(reset),
        .host_address(host_address),
        .host_write_data(host_write_data),
        .host_write_en(host_write_en),
        .host_read_en(host_read_en),
        .raster_x(raster_x),
        .raster_y(raster_y),
        .push_ready(push_ready),
        .host_read_data(host_read_data),
        .host_ready(host_ready),
        .push_valid(push_valid),
        .push_item(push_item),
        .pal_we(pal_we),
        .pal_addr(pal_addr),
        .pal_data(pal_data),
        .backdrop(backdrop)
    );

    vdp_vram_write_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) vram_write_fifo (
        .clk(clk),
        .reset(reset),
        .push_valid(push_valid),
        .push_item(push_item),
        .pop_ready(pop_ready),
        .push_ready(push_ready),
        .pop_valid(pop_valid),
        .pop_item(pop_item)
    );

    // Consumer, slot-timed port writes
    vdp_vram_writer vram_writer (
        .clk(clk),
        .reset(reset),
        .raster_x(raster_x),
        .pop_valid(pop_valid),
        .pop_item(pop_item),
        .pop_ready(pop_ready),
        .vram_address_even(vram_address_even),
        .vram_address_odd(vram_address_odd),
        .vram_write_data_even(vram_write_data_even),
        .vram_write_data_odd(vram_write_data_odd),
        .vram_we_even(vram_we_even),
        .vram_we_odd(vram_we_odd)
    );

    vdp_palette_output palette_output (
        .clk(clk),
        .pal_we(pal_we),
        .pal_addr(pal_addr),
        .pal_data(pal_data),
        .backdrop(backdrop),
        .active_display(active_display),
        .r(r),
        .g(g),
        .b(b)
    );

endmodule

// File: design/vdp_video_timing.sv
// Raster timing generator, horizontal order is front porch, sync, back porch, active
// Vertical order is active, front porch, sync, back porch
// Sync outputs are active low, strobes are single cycle and not meant for a monitor
// Totals must fit raster_x_t and raster_y_t

`timescale 1ns/1ps

module vdp_video_timing import vdp_pkg::*; #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT = 16,
    parameter int H_SYNC = 96,
    parameter int H_BACK = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT = 11,
    parameter int V_SYNC = 2,
    parameter int V_BACK = 31
) (
    input logic clk,
    input logic reset,
    output raster_x_t raster_x,
    output raster_y_t raster_y,
    output logic hsync,
    output logic vsync,
    output logic active_display,
    output logic line_ended,
    output logic frame_ended,
    output logic active_frame_ended
);
    localparam int H_BLANK = H_FRONT + H_SYNC + H_BACK;
    localparam int H_TOTAL = H_BLANK + H_ACTIVE;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    localparam raster_x_t X_LAST = raster_x_t'(H_TOTAL - 1);
    localparam raster_x_t X_SYNC_START = raster_x_t'(H_FRONT);
    localparam raster_x_t X_SYNC_END = raster_x_t'(H_FRONT + H_SYNC);
    localparam raster_x_t X_ACTIVE_START = raster_x_t'(H_BLANK);

    localparam raster_y_t Y_LAST = raster_y_t'(V_TOTAL - 1);
    localparam raster_y_t Y_ACTIVE_LAST = raster_y_t'(V_ACTIVE - 1);
    localparam raster_y_t Y_SYNC_START = raster_y_t'(V_ACTIVE + V_FRONT);
    localparam raster_y_t Y_SYNC_END = raster_y_t'(V_ACTIVE + V_FRONT + V_SYNC);

    always_ff @(posedge clk) begin
        if (reset) begin
            raster_x <= '0;
            raster_y <= '0;
        end else if (line_ended) begin
            raster_x <= '0;
            raster_y <= frame_ended ? '0 : raster_y + 1'b1;
        end else begin
            raster_x <= raster_x + 1'b1;
        end
    end

    assign hsync = !(raster_x >= X_SYNC_START && raster_x < X_SYNC_END);
    assign vsync = !(raster_y >= Y_SYNC_START && raster_y < Y_SYNC_END);

    assign active_display = (raster_x >= X_ACTIVE_START) && (raster_y <= Y_ACTIVE_LAST);

    assign line_ended = (raster_x == X_LAST);
    assign frame_ended = line_ended && (raster_y == Y_LAST);
    assign active_frame_ended = line_ended && (raster_y == Y_ACTIVE_LAST);

endmodule

// File: design/vdp_vram_write_fifo.sv
// Synchronous queue of pending VRAM writes, first in first out
// FIFO_DEPTH must be 2 or more, any value works since pointers wrap explicitly
// Push and pop may happen in the same cycle
// A full queue refuses pushes even while it pops

`timescale 1ns/1ps

module vdp_vram_write_fifo import vdp_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input logic clk,
    input logic reset,
    input logic push_valid,
    input vram_write_t push_item,
    input logic pop_ready,
    output logic push_ready,
    output logic pop_valid,
    output vram_write_t pop_item
);
    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int COUNT_W = $clog2(FIFO_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);
    localparam logic [COUNT_W-1:0] FULL_COUNT = COUNT_W'(FIFO_DEPTH);

    vram_write_t mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [COUNT_W-1:0] count;
    logic push_fire;
    logic pop_fire;

    assign pop_valid = (count != '0);
    // Ready depends on occupancy only
    assign push_ready = (count != FULL_COUNT);
    assign pop_item = mem[rd_ptr];

    assign push_fire = push_valid && push_ready;
    assign pop_fire = pop_valid && pop_ready;

    always_ff @(posedge clk) begin
        if (push_fire) begin
            mem[wr_ptr] <= push_item;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_fire) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + COUNT_W'(push_fire) - COUNT_W'(pop_fire);
        end
    end

endmodule

// File: design/vdp_vram_writer.sv
// Drains queued writes into the VRAM ports, one write per 8-cycle slot
// Address bit 0 picks the port, the write enable lasts one cycle
// Port address and data hold their last values between writes

`timescale 1ns/1ps

module vdp_vram_writer import vdp_pkg::*; (
    input logic clk,
    input logic reset,
    input raster_x_t raster_x,
    input logic pop_valid,
    input vram_write_t pop_item,
    output logic pop_ready,
    output port_addr_t vram_address_even,
    output port_addr_t vram_address_odd,
    output word_t vram_write_data_even,
    output word_t vram_write_data_odd,
    output logic vram_we_even,
    output logic vram_we_odd
);
    logic take;
    logic odd_port;

    assign pop_ready = (raster_x[2:0] == VRAM_WRITE_SLOT);
    assign take = pop_ready && pop_valid;
    assign odd_port = pop_item.addr[0];

    always_ff @(posedge clk) begin
        if (reset) begin
            vram_we_even <= 1'b0;
            vram_we_odd <= 1'b0;
        end else begin
            vram_we_even <= take && !odd_port;
            vram_we_odd <= take && odd_port;
        end
    end

    always_ff @(posedge clk) begin
        if (take && !odd_port) begin
            vram_address_even <= pop_item.addr[14:1];
            vram_write_data_even <= pop_item.data;
        end
        if (take && odd_port) begin
            vram_address_odd <= pop_item.addr[14:1];
            vram_write_data_odd <= pop_item.data;
        end
    end

endmodule

// File: run_verilator.sh
#!/bin/sh
# Build and run the display core testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --top-module vdp_tb -f vlog.f; then
    echo "Verilator build failed"
    exit 1
fi

if ! output=$(./obj_dir/Vvdp_tb); then
    echo "$output"
    echo "Simulation exited with an error status"
    exit 1
fi
echo "$output"

if printf '%s\n' "$output" | grep -qx "Testbench passed"; then
    exit 0
fi
echo "Pass message not found in the simulation output"
exit 1

// File: verification/vdp_checker.sv
// Reference model of the display core, sampled on the falling clock edge
// Models raster, readback, palette, backdrop and VRAM write order from reset
// Assumes the palette RAM starts black and reset is applied once

`timescale 1ns/1ps

module vdp_checker import vdp_pkg::*; #(
    parameter int H_ACTIVE = 24,
    parameter int H_FRONT = 2,
    parameter int H_SYNC = 4,
    parameter int H_BACK = 2,
    parameter int V_ACTIVE = 6,
    parameter int V_FRONT = 1,
    parameter int V_SYNC = 2,
    parameter int V_BACK = 1,
    parameter int FIFO_DEPTH = 4
) (
    input logic clk,
    input logic reset,
    input host_addr_t host_address,
    input word_t host_write_data,
    input logic host_write_en,
    input logic host_read_en,
    input word_t host_read_data,
    input logic host_ready,
    input logic [3:0] r,
    input logic [3:0] g,
    input logic [3:0] b,
    input logic vga_hsync,
    input logic vga_vsync,
    input logic active_display,
    input logic line_ended,
    input logic frame_ended,
    input logic active_frame_ended,
    input port_addr_t vram_address_even,
    input port_addr_t vram_address_odd,
    input word_t vram_write_data_even,
    input word_t vram_write_data_odd,
    input logic vram_we_even,
    input logic vram_we_odd,
    output int check_count,
    output int error_count,
    output int vram_count,
    output int stall_count,
    output int pending_count
);
    localparam int H_BLANK = H_FRONT + H_SYNC + H_BACK;
    localparam int H_TOTAL = H_BLANK + H_ACTIVE;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    int checks = 0;
    int errors = 0;
    int vram_writes = 0;
    int stalls = 0;
    int x;
    int y;
    logic last_was_slot;
    word_t read_expected;
    word_t palette [256] = '{default: '0};
    pal_index_t pal_ptr;
    pal_index_t backdrop;
    vram_addr_t vram_addr;
    vram_addr_t vram_inc;
    vram_write_t expected_writes [$];
    color_t color_pipe [2];

    assign check_count = checks;
    assign error_count = errors;
    assign vram_count = vram_writes;
    assign stall_count = stalls;
    assign pending_count = expected_writes.size();

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("[ERROR] %s: got %h, expected %h", name, got, expected);
        end
    endtask

    task automatic report_failure(input string text);
        errors++;
        $display("Error at %0t ns: %s", $time, text);
    endtask

    function automatic logic model_active();
        return (x >= H_BLANK) && (y < V_ACTIVE);
    endfunction

    task automatic reset_model();
        x = 0;
        y = 0;
        last_was_slot = 1'b0;
        read_expected = '0;
        pal_ptr = '0;
        backdrop = '0;
        vram_addr = '0;
        vram_inc = '0;
        expected_writes.delete();
        color_pipe[0] = '0;
        color_pipe[1] = '0;
    endtask

    task automatic check_raster();
        logic end_of_line;
        logic in_hsync;
        logic in_vsync;
        end_of_line = (x == H_TOTAL - 1);
        in_hsync = (x >= H_FRONT) && (x < H_FRONT + H_SYNC);
        in_vsync = (y >= V_ACTIVE + V_FRONT) && (y < V_ACTIVE + V_FRONT + V_SYNC);
        check_value("vga_hsync", 32'(vga_hsync), 32'(!in_hsync));
        check_value("vga_vsync", 32'(vga_vsync), 32'(!in_vsync));
        check_value("active_display", 32'(active_display), 32'(model_active()));
        check_value("line_ended", 32'(line_ended), 32'(end_of_line));
        check_value("frame_ended", 32'(frame_ended), 32'(end_of_line && y == V_TOTAL - 1));
        check_value("active_frame_ended", 32'(active_frame_ended),
                    32'(end_of_line && y == V_ACTIVE - 1));
    endtask

    // Colour seen two cycles after the active flag that selects it
    task automatic check_color();
        check_value("rgb", 32'({r, g, b}), 32'(color_pipe[1]));
        color_pipe[1] = color_pipe[0];
        color_pipe[0] = model_active() ? palette[backdrop][11:0] : '0;
    endtask

    task automatic check_vram();
        vram_write_t expected;
        if (vram_we_even && vram_we_odd) begin
            report_failure("both VRAM write enables are high in the same cycle");
        end else if (vram_we_even || vram_we_odd) begin
            vram_writes++;
            if (!last_was_slot) begin
                report_failure("VRAM write enable not in the cycle after a write slot");
            end
            if (expected_writes.size() == 0) begin
                report_failure("VRAM write enable with no accepted write pending");
            end else begin
                expected = expected_writes.pop_front();
                check_value("vram_we_odd", 32'(vram_we_odd), 32'(expected.addr[0]));
                if (vram_we_even) begin
                    check_value("vram_address_even", 32'(vram_address_even),
                                32'(expected.addr[14:1]));
                    check_value("vram_write_data_even", 32'(vram_write_data_even),
                                32'(expected.data));
                end else begin
                    check_value("vram_address_odd", 32'(vram_address_odd),
                                32'(expected.addr[14:1]));
                    check_value("vram_write_data_odd", 32'(vram_write_data_odd),
                                32'(expected.data));
                end
            end
        end
        // Pending entries now match the queue occupancy of this cycle
        if (expected_writes.size() > FIFO_DEPTH) begin
            report_failure("more VRAM writes in flight than the queue can hold");
        end
        check_value("host_ready", 32'(host_ready), 32'(expected_writes.size() != FIFO_DEPTH));
    endtask

    task automatic apply_host();
        vram_write_t item;
        if (host_write_en && !host_ready) begin
            stalls++;
        end
        if (host_write_en && host_ready) begin
            case (host_address)
                REG_PALETTE_ADDR: pal_ptr = host_write_data[7:0];
                REG_PALETTE_DATA: begin
                    palette[pal_ptr] = host_write_data;
                    pal_ptr = pal_ptr + 8'd1;
                end
                REG_VRAM_ADDR: vram_addr = host_write_data[14:0];
                REG_VRAM_DATA: begin
                    item.addr = vram_addr;
                    item.data = host_write_data;
                    expected_writes.push_back(item);
                    vram_addr = vram_addr + vram_inc;
                end
                REG_VRAM_INC: vram_inc = host_write_data[14:0];
                REG_BACKDROP: backdrop = host_write_data[7:0];
                default: ;
            endcase
        end
        if (host_read_en && host_address == REG_RASTER_X) begin
            read_expected = word_t'(x);
        end else if (host_read_en && host_address == REG_RASTER_Y) begin
            read_expected = word_t'(y);
        end
    endtask

    task automatic advance_raster();
        last_was_slot = ((x % 8) == int'(VRAM_WRITE_SLOT));
        if (x == H_TOTAL - 1) begin
            x = 0;
            y = (y == V_TOTAL - 1) ? 0 : y + 1;
        end else begin
            x = x + 1;
        end
    endtask

    always @(negedge clk) begin
        if (reset) begin
            reset_model();
        end else begin
            check_raster();
            check_value("host_read_data", 32'(host_read_data), 32'(read_expected));
            check_color();
            check_vram();
            apply_host();
            advance_raster();
        end
    end

endmodule

// File: verification/vdp_props.sv
// Concurrent assertions bound into vdp_top
// H_TOTAL follows the timing parameters of the bound instance
// Needs a simulator run with assertions enabled

`timescale 1ns/1ps

module vdp_props #(
    parameter int H_TOTAL = 800
) (
    input logic clk,
    input logic reset,
    input logic vram_we_even,
    input logic vram_we_odd,
    input logic active_display,
    input logic [3:0] r,
    input logic [3:0] g,
    input logic [3:0] b,
    input logic line_ended,
    input logic vga_hsync
);
    logic hsync_pending;
    int hsync_wait;

    // Cycles since the first unanswered line_ended with no hsync pulse yet
    always_ff @(posedge clk) begin
        if (reset) begin
            hsync_pending <= 1'b0;
            hsync_wait <= 0;
        end else if (hsync_pending && !vga_hsync) begin
            hsync_pending <= 1'b0;
        end else if (hsync_pending) begin
            hsync_wait <= hsync_wait + 1;
        end else if (line_ended) begin
            hsync_pending <= 1'b1;
            hsync_wait <= 0;
        end
    end

    assert property (@(posedge clk) disable iff (reset) !(vram_we_even && vram_we_odd))
        else $error("both VRAM write enables high");

    assert property (@(posedge clk) disable iff (reset)
        !$past(active_display, 2) |-> {r, g, b} == 12'd0)
        else $error("RGB not blank two cycles after inactive display");

    assert property (@(posedge clk) disable iff (reset) hsync_pending |-> hsync_wait < H_TOTAL)
        else $error("no hsync pulse within a line after line_ended");

endmodule

bind vdp_top vdp_props #(
    .H_TOTAL(H_FRONT + H_SYNC + H_BACK + H_ACTIVE)
) props (
    .clk(clk),
    .reset(reset),
    .vram_we_even(vram_we_even),
    .vram_we_odd(vram_we_odd),
    .active_display(active_display),
    .r(r),
    .g(g),
    .b(b),
    .line_ended(line_ended),
    .vga_hsync(vga_hsync)
);

// File: verification/vdp_tb.sv
// Testbench for the display core on a 32 by 10 raster with a four-entry VRAM queue
// Host operations come from a table, VRAM burst data from a 16-bit LFSR
// Comparing is done in vdp_checker

`timescale 1ns/1ps

module vdp_tb import vdp_pkg::*; ();
    localparam int H_ACTIVE = 24;
    localparam int H_FRONT = 2;
    localparam int H_SYNC = 4;
    localparam int H_BACK = 2;
    localparam int V_ACTIVE = 6;
    localparam int V_FRONT = 1;
    localparam int V_SYNC = 2;
    localparam int V_BACK = 1;
    localparam int FIFO_DEPTH = 4;

    typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_WAIT} op_kind_t;

    // For OP_WAIT the data field is a cycle count
    typedef struct packed {
        op_kind_t kind;
        host_addr_t addr;
        word_t data;
    } host_op_t;

    logic clk = 1'b0;
    logic reset;
    host_addr_t host_address;
    word_t host_write_data;
    logic host_write_en;
    logic host_read_en;
    word_t host_read_data;
    logic host_ready;
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
    logic vga_hsync;
    logic vga_vsync;
    logic active_display;
    logic line_ended;
    logic frame_ended;
    logic active_frame_ended;
    port_addr_t vram_address_even;
    port_addr_t vram_address_odd;
    word_t vram_write_data_even;
    word_t vram_write_data_odd;
    logic vram_we_even;
    logic vram_we_odd;

    int check_count;
    int error_count;
    int vram_count;
    int stall_count;
    int pending_count;

    host_op_t ops [$];
    logic [15:0] lfsr_state = 16'd33862;
    int cycle_count = 0;
    int cycle_limit = 0;
    int tb_errors = 0;

    vdp_top #(
        .H_ACTIVE(H_ACTIVE),
        .H_FRONT(H_FRONT),
        .H_SYNC(H_SYNC),
        .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE),
        .V_FRONT(V_FRONT),
        .V_SYNC(V_SYNC),
        .V_BACK(V_BACK),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) uut (.*);

    vdp_checker #(
        .H_ACTIVE(H_ACTIVE),
        .H_FRONT(H_FRONT),
        .H_SYNC(H_SYNC),
        .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE),
        .V_FRONT(V_FRONT),
        .V_SYNC(V_SYNC),
        .V_BACK(V_BACK),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) scoreboard (.*);

    always #50 clk = ~clk;

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    task automatic take_random_word(output word_t word);
        word = '0;
        for (int i = 0; i < 16; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            word = {word[14:0], lfsr_state[0]};
        end
    endtask

    task automatic add_op(input op_kind_t kind, input host_addr_t addr, input word_t data);
        ops.push_back('{kind, addr, data});
    endtask

    task automatic build_table();
        word_t word;
        add_op(OP_WAIT, '0, 16'd40);
        add_op(OP_READ, REG_RASTER_X, '0);
        add_op(OP_WAIT, '0, 16'd3);
        add_op(OP_READ, REG_RASTER_Y, '0);
        add_op(OP_WAIT, '0, 16'd17);
        add_op(OP_READ, REG_RASTER_X, '0);
        add_op(OP_READ, REG_RASTER_Y, '0);
        // Three palette entries from index 5
        add_op(OP_WRITE, REG_PALETTE_ADDR, 16'd5);
        add_op(OP_WRITE, REG_PALETTE_DATA, 16'h0f00);
        add_op(OP_WRITE, REG_PALETTE_DATA, 16'h00f0);
        add_op(OP_WRITE, REG_PALETTE_DATA, 16'hfa5c);
        // Each entry as backdrop for more than a frame
        for (int i = 5; i < 8; i++) begin
            add_op(OP_WRITE, REG_BACKDROP, 16'(i));
            add_op(OP_WAIT, '0, 16'd330);
            add_op(OP_READ, REG_RASTER_Y, '0);
        end
        add_op(OP_WRITE, REG_VRAM_INC, 16'd3);
        add_op(OP_WRITE, REG_VRAM_ADDR, 16'h1234);
        for (int i = 0; i < 4; i++) begin
            add_op(OP_WRITE, REG_VRAM_DATA, 16'ha000 + 16'(i));
            add_op(OP_WAIT, '0, 16'd5);
        end
        // Burst that wraps the address and overruns the queue
        add_op(OP_WRITE, REG_VRAM_ADDR, 16'h7ffb);
        for (int i = 0; i < 8; i++) begin
            take_random_word(word);
            add_op(OP_WRITE, REG_VRAM_DATA, word);
        end
        add_op(OP_WAIT, '0, 16'd120);
    endtask

    // Each driving task starts and ends 1 ns after a rising edge
    task automatic host_write(input host_addr_t addr, input word_t data);
        host_address = addr;
        host_write_data = data;
        host_write_en = 1'b1;
        @(negedge clk);
        while (!host_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        host_write_en = 1'b0;
    endtask

    task automatic host_read(input host_addr_t addr);
        host_address = addr;
        host_read_en = 1'b1;
        @(posedge clk);
        #1;
        host_read_en = 1'b0;
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(posedge clk);
        end
        #1;
    endtask

    task automatic apply_op(input host_op_t op);
        case (op.kind)
            OP_WRITE: host_write(op.addr, op.data);
            OP_READ: host_read(op.addr);
            default: idle_cycles(int'(op.data));
        endcase
    endtask

    task automatic check_end_of_run();
        int vram_expected;
        vram_expected = 0;
        foreach (ops[i]) begin
            if (ops[i].kind == OP_WRITE && ops[i].addr == REG_VRAM_DATA) begin
                vram_expected++;
            end
        end
        if (pending_count != 0) begin
            tb_errors++;
            $display("VRAM writes were still pending at the end of the run");
        end
        if (vram_count != vram_expected) begin
            tb_errors++;
            $display("Saw %0d VRAM writes on the ports instead of %0d", vram_count, vram_expected);
        end
        if (stall_count == 0) begin
            tb_errors++;
            $display("host_ready never dropped during the VRAM burst");
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        reset = 1'b1;
        host_address = '0;
        host_write_data = '0;
        host_write_en = 1'b0;
        host_read_en = 1'b0;
        build_table();
        cycle_limit = ops.size() * 64 + 2000;
        repeat (10) begin
            @(posedge clk);
        end
        #1;
        reset = 1'b0;
        foreach (ops[i]) begin
            apply_op(ops[i]);
        end
        check_end_of_run();
        $display("Checks %0d, errors %0d + %0d, VRAM writes %0d, stalled cycles %0d",
                 check_count, error_count, tb_errors, vram_count, stall_count);
        if (error_count == 0 && tb_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
design/vdp_pkg.sv
design/vdp_video_timing.sv
design/vdp_host_regs.sv
design/vdp_vram_write_fifo.sv
design/vdp_vram_writer.sv
design/vdp_palette_output.sv
design/vdp_top.sv
verification/vdp_props.sv
verification/vdp_checker.sv
verification/vdp_tb.sv
